// File: Makefile
# Verilator build and run of the CPU monitor testbench
LOG := sim.log
SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/Vcpu_monitor_tb: files.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cpu_monitor_tb -o Vcpu_monitor_tb

run: obj_dir/Vcpu_monitor_tb
	./obj_dir/Vcpu_monitor_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module cpu_monitor_top

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
+incdir+source
source/mips_report_pkg.sv
source/display_pkg.sv
source/monitor_status_if.sv
source/perf_monitor.sv
source/digit_selector.sv
source/segment_digit.sv
source/panel_driver.sv
source/cpu_monitor_top.sv
verification/cpu_monitor_properties.sv
verification/cpu_monitor_tb.sv

// File: source/cpu_monitor_defs.svh
// CPU monitor widths and counts shared by the packages and the RTL
`ifndef CPU_MONITOR_DEFS_SVH
`define CPU_MONITOR_DEFS_SVH

// ==========================================================================
// Performance counters
// ==========================================================================

`define COUNTER_WIDTH 32	// Cycle and retired-instruction counters

// ==========================================================================
// Processor-side inputs
// ==========================================================================

`define ADDRESS_WIDTH 22	// Word address of the current PC

// Only the low byte of a report value reaches the display
`define REPORT_VALUE_WIDTH 8

// ==========================================================================
// Seven-segment panel
// ==========================================================================

`define DIGIT_COUNT 8	// HEX7..HEX0 on the board
`define NIBBLE_WIDTH 4	// One hex digit
`define SEGMENT_WIDTH 7	// Segments a..g, no decimal point

`endif

// File: source/cpu_monitor_top.sv
// CPU status monitor top level, from counters and reports to the seven-segment panel
`timescale 1ns/1ns
`default_nettype none

`include "cpu_monitor_defs.svh"

module cpu_monitor_top
(
	input logic i_Clk,
	input logic i_Reset_n,	// Board key, active low
	input logic i_LoaderDone,	// Flash image loaded
	input logic i_Retire,	// Retire strobe from the pipe
	input logic i_Report,	// Coprocessor-0 move strobe
	input logic [1:0] i_ReportCode,	// NOOP, PASS, FAIL, DONE
	input logic [`REPORT_VALUE_WIDTH-1:0] i_ReportValue,
	input logic [`ADDRESS_WIDTH-1:0] i_Pc,	// Current fetch PC
	input logic [1:0] i_Mode,	// SW[1:0]
	output logic [`SEGMENT_WIDTH-1:0] o_Segments [`DIGIT_COUNT],	// HEX0..HEX7
	output logic o_DoneLed,
	output logic o_RunLed
);

	import mips_report_pkg::*;
	import display_pkg::*;

	// ======================================================================
	// Internal wiring
	// ======================================================================

	wire Internal_Reset_n = i_Reset_n;	// No PLL lock to qualify with

	nibble_t Nibbles [`DIGIT_COUNT];	// Selector to decoders
	segments_t DigitSegments [`DIGIT_COUNT];	// Decoders to panel
	displayMode_e SelMode;
	reportCode_e SelCode;

	monitorStatus_if statusIf ();

	// Counters and report hold
	perf_monitor u_perfMonitor (
		.i_Clk(i_Clk),
		.Internal_Reset_n(Internal_Reset_n),
		.i_LoaderDone(i_LoaderDone),
		.i_Retire(i_Retire),
		.i_Report(i_Report),
		.i_ReportCode(reportCode_e'(i_ReportCode)),
		.i_ReportValue(i_ReportValue),
		.status(statusIf.source)
	);

	digit_selector u_digitSelector (
		.i_Clk(i_Clk),
		.Internal_Reset_n(Internal_Reset_n),
		.i_Mode(displayMode_e'(i_Mode)),
		.i_Pc(i_Pc),
		.status(statusIf.sink),
		.o_Nibbles(Nibbles),
		.o_Mode(SelMode),
		.o_ReportCode(SelCode)
	);

	// One decoder per digit
	for (genvar d = 0; d < `DIGIT_COUNT; d++)
	begin : g_digit
		segment_digit u_segmentDigit (
			.i_Clk(i_Clk),
			.Internal_Reset_n(Internal_Reset_n),
			.i_Nibble(Nibbles[d]),
			.o_Segments(DigitSegments[d])
		);
	end

	panel_driver u_panelDriver (
		.i_Clk(i_Clk),
		.Internal_Reset_n(Internal_Reset_n),
		.i_Mode(SelMode),
		.i_ReportCode(SelCode),
		.i_DigitSegments(DigitSegments),
		.o_Segments(o_Segments),
		.o_DoneLed(o_DoneLed),
		.o_RunLed(o_RunLed)
	);

endmodule

`default_nettype wire

// File: source/digit_selector.sv
// Mode-selected nibble registers that feed the eight display digits
`timescale 1ns/1ns
`default_nettype none

`include "cpu_monitor_defs.svh"

module digit_selector
(
	input logic i_Clk,
	input logic Internal_Reset_n,
	input display_pkg::displayMode_e i_Mode,	// Board switches
	input logic [`ADDRESS_WIDTH-1:0] i_Pc,
	monitorStatus_if.sink status,
	output display_pkg::nibble_t o_Nibbles [`DIGIT_COUNT],
	output display_pkg::displayMode_e o_Mode,	// Aligned with o_Nibbles
	output mips_report_pkg::reportCode_e o_ReportCode
);

	import display_pkg::*;
	import mips_report_pkg::*;

	nibble_t NextNibbles [`DIGIT_COUNT];

	// ======================================================================
	// Digit contents per mode
	// ======================================================================

	always_comb
	begin
		NextNibbles = '{default: '0};	// Unused digits read 0
		case (i_Mode)
			STATUS:
			begin
				// Value on the right, PC low byte on the left
				NextNibbles[0] = status.ReportValue[`NIBBLE_WIDTH-1:0];
				NextNibbles[1] = status.ReportValue[2*`NIBBLE_WIDTH-1:`NIBBLE_WIDTH];
				NextNibbles[6] = i_Pc[`NIBBLE_WIDTH-1:0];
				NextNibbles[7] = i_Pc[2*`NIBBLE_WIDTH-1:`NIBBLE_WIDTH];
			end
			CYCLES:
				for (int d = 0; d < `DIGIT_COUNT; d++)
					NextNibbles[d] = status.CycleCount[d*`NIBBLE_WIDTH +: `NIBBLE_WIDTH];
			INSTRUCTIONS:
				for (int d = 0; d < `DIGIT_COUNT; d++)
					NextNibbles[d] = status.InstrCount[d*`NIBBLE_WIDTH +: `NIBBLE_WIDTH];
			default:
				NextNibbles = '{default: '0};	// SPARE
		endcase
	end

	// Mode and code ride along so the panel lines up with the digits
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			o_Nibbles <= '{default: '0};
			o_Mode <= STATUS;
			o_ReportCode <= NOOP;
		end
		else
		begin
			o_Nibbles <= NextNibbles;
			o_Mode <= i_Mode;
			o_ReportCode <= status.ReportCode;
		end
	end

endmodule

`default_nettype wire

// File: source/display_pkg.sv
// Display mode encoding, digit types and seven-segment glyph tables
`default_nettype none

`include "cpu_monitor_defs.svh"

package display_pkg;

	// Switch-selected display content
	typedef enum logic [1:0]
	{
		STATUS = 2'd0,	// Report value, glyph and PC
		CYCLES = 2'd1,	// Cycle counter in hex
		INSTRUCTIONS = 2'd2,	// Retired instructions in hex
		SPARE = 2'd3	// Free slot, shows zeros
	} displayMode_e;

	typedef logic [`NIBBLE_WIDTH-1:0] nibble_t;

	// Active low, bit 0 drives segment a, bit 6 segment g
	typedef logic [`SEGMENT_WIDTH-1:0] segments_t;

	// ======================================================================
	// Glyph tables
	// ======================================================================

	// Hex glyphs, index is the nibble value
	localparam segments_t segmentTable [2**`NIBBLE_WIDTH] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,	// 0 1 2 3
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,	// 4 5 6 7
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,	// 8 9 A b
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110	// C d E F
	};

	// Report glyphs for the status digit
	localparam segments_t glyphPass = 7'b0001100;	// P
	localparam segments_t glyphFail = 7'b0001110;	// F
	localparam segments_t glyphDone = 7'b0100001;	// d

	// All segments dark
	localparam segments_t glyphBlank = 7'b1111111;

endpackage

`default_nettype wire

// File: source/mips_report_pkg.sv
// Processor report codes and counter word types for the status monitor
`default_nettype none

`include "cpu_monitor_defs.svh"

package mips_report_pkg;

	// Coprocessor-0 move codes, as encoded by the test programs
	typedef enum logic [1:0]
	{
		NOOP = 2'd0,	// No significance
		PASS = 2'd1,	// A test passed
		FAIL = 2'd2,	// A test failed
		DONE = 2'd3	// Program has finished
	} reportCode_e;

	// Counter word, wraps at full width
	typedef logic [`COUNTER_WIDTH-1:0] counter_t;

	// Low part of the reported value
	typedef logic [`REPORT_VALUE_WIDTH-1:0] reportValue_t;

endpackage

`default_nettype wire

// File: source/monitor_status_if.sv
// Held counters and report carried from the performance monitor to the selector
`timescale 1ns/1ns
`default_nettype none

interface monitorStatus_if;

	import mips_report_pkg::*;

	// All registered levels, sampled freely by the sink
	counter_t CycleCount;	// Running cycles
	counter_t InstrCount;	// Retired instructions
	reportCode_e ReportCode;	// Last non-NOOP report
	reportValue_t ReportValue;	// Value that came with it

	// Monitor side
	modport source
	(
		output CycleCount, InstrCount, ReportCode, ReportValue
	);

	// Display side
	modport sink
	(
		input CycleCount, InstrCount, ReportCode, ReportValue
	);

endinterface

`default_nettype wire

// File: source/panel_driver.sv
// Panel driver with report glyph, status-digit override and LED outputs
`timescale 1ns/1ns
`default_nettype none

`include "cpu_monitor_defs.svh"

module panel_driver
(
	input logic i_Clk,
	input logic Internal_Reset_n,
	input display_pkg::displayMode_e i_Mode,	// Registered in the selector
	input mips_report_pkg::reportCode_e i_ReportCode,
	input display_pkg::segments_t i_DigitSegments [`DIGIT_COUNT],
	output display_pkg::segments_t o_Segments [`DIGIT_COUNT],
	output logic o_DoneLed,	// Green LED 0
	output logic o_RunLed	// Red LED 0
);

	import display_pkg::*;
	import mips_report_pkg::*;

	localparam int GlyphDigit = 2;	// HEX2 carries the pass/fail/done glyph

	segments_t Glyph;
	logic ShowGlyph;	// Status mode, delayed with the glyph

	// ======================================================================
	// Glyph and LED registers, same stage as the digit decoders
	// ======================================================================

	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			Glyph <= glyphBlank;
			ShowGlyph <= 1'b0;
			o_DoneLed <= 1'b0;
			o_RunLed <= 1'b0;	// Both dark until the first edge
		end
		else
		begin
			case (i_ReportCode)
				PASS: Glyph <= glyphPass;
				FAIL: Glyph <= glyphFail;
				DONE: Glyph <= glyphDone;
				default: Glyph <= glyphBlank;	// NOOP
			endcase
			ShowGlyph <= (i_Mode == STATUS);
			o_DoneLed <= (i_ReportCode == DONE);
			o_RunLed <= (i_ReportCode != DONE);
		end
	end

	// Digit 2 swaps to the glyph in status mode, the rest pass through
	always_comb
	begin
		for (int d = 0; d < `DIGIT_COUNT; d++)
			o_Segments[d] = i_DigitSegments[d];
		if (ShowGlyph)
			o_Segments[GlyphDigit] = Glyph;
	end

endmodule

`default_nettype wire

// File: source/perf_monitor.sv
// Performance monitor with cycle and retire counters and the report hold register
`timescale 1ns/1ns
`default_nettype none

module perf_monitor
(
	input logic i_Clk,
	input logic Internal_Reset_n,
	input logic i_LoaderDone,	// Program image is in memory
	input logic i_Retire,	// One instruction left the pipe
	input logic i_Report,	// Qualifies code and value
	input mips_report_pkg::reportCode_e i_ReportCode,
	input mips_report_pkg::reportValue_t i_ReportValue,
	monitorStatus_if.source status
);

	import mips_report_pkg::*;

	// ======================================================================
	// State
	// ======================================================================

	logic Running;	// Loader finished and program not done
	counter_t CycleCount;
	counter_t InstrCount;
	reportCode_e HeldCode;
	reportValue_t HeldValue;

	// Stops counting as soon as DONE is held
	assign Running = i_LoaderDone && (HeldCode != DONE);

	// ======================================================================
	// Counters
	// ======================================================================

	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			CycleCount <= '0;
			InstrCount <= '0;
		end
		else if (Running)
		begin
			CycleCount <= CycleCount + 1'b1;	// Every running cycle
			if (i_Retire)
				InstrCount <= InstrCount + 1'b1;	// Strobe sampled on this edge
		end
	end

	// Report hold, NOOP moves are dropped
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			HeldCode <= NOOP;
			HeldValue <= '0;
		end
		else if (i_Report && (i_ReportCode != NOOP))
		begin
			HeldCode <= i_ReportCode;	// Also replaces a held DONE
			HeldValue <= i_ReportValue;
		end
	end

	// Out to the selector
	assign status.CycleCount = CycleCount;
	assign status.InstrCount = InstrCount;
	assign status.ReportCode = HeldCode;
	assign status.ReportValue = HeldValue;

endmodule

`default_nettype wire

// File: source/segment_digit.sv
// Registered hex-to-seven-segment decoder for one display digit
`timescale 1ns/1ns
`default_nettype none

module segment_digit
(
	input logic i_Clk,
	input logic Internal_Reset_n,
	input display_pkg::nibble_t i_Nibble,	// Hex value to show
	output display_pkg::segments_t o_Segments	// Active low, a in bit 0
);

	import display_pkg::*;

	// ======================================================================
	// Decode register
	// ======================================================================

	// One cycle behind the nibble register
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			o_Segments <= glyphBlank;	// Dark until the first clock
		end
		else
		begin
			// Straight table lookup
			o_Segments <= segmentTable[i_Nibble];
		end
	end

endmodule

`default_nettype wire

// File: verification/cpu_monitor_properties.sv
// Bound assertions on the performance counters and the held report code
`timescale 1ns/1ns
`default_nettype none

module cpu_monitor_properties
(
	input logic i_Clk,
	input logic Internal_Reset_n,
	input logic i_Retire,
	input logic i_Report,
	input mips_report_pkg::reportCode_e i_ReportCode,
	input logic Running,
	input mips_report_pkg::counter_t CycleCount,
	input mips_report_pkg::counter_t InstrCount,
	input mips_report_pkg::reportCode_e HeldCode
);

	import mips_report_pkg::*;

	logic NewReport;	// A report that is not dropped
	int FailCount = 0;	// Failed assertions so far

	assign NewReport = i_Report && (i_ReportCode != NOOP);

	// ========================================================================
	// Counter rules
	// ========================================================================

	CountersHold: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		!Running |=> $stable(CycleCount) && $stable(InstrCount))
		else
		begin
			$error("Counters moved while the program was not running");
			FailCount++;
		end

	CycleStep: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		Running |=> CycleCount == $past(CycleCount) + 32'd1)	// Wraps at full width
		else
		begin
			$error("Cycle counter did not advance by one while running");
			FailCount++;
		end

	// Only a running retire strobe moves it
	InstrOnRetire: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		InstrCount != $past(InstrCount) |-> $past(i_Retire) && $past(Running))
		else
		begin
			$error("Instruction counter changed without a running retire strobe");
			FailCount++;
		end

	// ========================================================================
	// Report hold
	// ========================================================================

	DoneHeld: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		HeldCode == DONE && !NewReport |=> HeldCode == DONE)
		else
		begin
			$error("DONE code left without a new report");
			FailCount++;
		end

endmodule

bind perf_monitor cpu_monitor_properties u_properties (
	.i_Clk(i_Clk),
	.Internal_Reset_n(Internal_Reset_n),
	.i_Retire(i_Retire),
	.i_Report(i_Report),
	.i_ReportCode(i_ReportCode),
	.Running(Running),
	.CycleCount(CycleCount),
	.InstrCount(InstrCount),
	.HeldCode(HeldCode)
);

`default_nettype wire

// File: verification/cpu_monitor_tb.sv
// CPU monitor testbench with a reference model of counters, reports and the panel pipeline
`timescale 1ns/1ns
`default_nettype none

`include "cpu_monitor_defs.svh"

module cpu_monitor_tb;

	localparam logic [1:0] Noop = 2'd0;	// Report codes
	localparam logic [1:0] Pass = 2'd1;
	localparam logic [1:0] Fail = 2'd2;
	localparam logic [1:0] Done = 2'd3;
	localparam logic [1:0] ModeStatus = 2'd0;
	localparam logic [1:0] ModeCycles = 2'd1;
	localparam logic [1:0] ModeInstr = 2'd2;
	localparam logic [1:0] ModeSpare = 2'd3;
	localparam int CycleLimit = 3000;	// About twice the whole test run
	localparam logic [6:0] Blank = 7'h7F;
	localparam logic [6:0] GlyphP = 7'h0C;
	localparam logic [6:0] GlyphF = 7'h0E;
	localparam logic [6:0] GlyphD = 7'h21;
	// Active-low hex glyphs, segment a in bit 0
	localparam logic [6:0] HexGlyph [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,
		7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

	logic i_Clk;
	logic i_Reset_n;
	logic i_LoaderDone;
	logic i_Retire;
	logic i_Report;
	logic [1:0] i_ReportCode;
	logic [`REPORT_VALUE_WIDTH-1:0] i_ReportValue;
	logic [`ADDRESS_WIDTH-1:0] i_Pc;
	logic [1:0] i_Mode;
	logic [`SEGMENT_WIDTH-1:0] o_Segments [`DIGIT_COUNT];
	logic o_DoneLed;
	logic o_RunLed;

	logic [31:0] ExpCycles;	// Reference counters and held report
	logic [31:0] ExpInstr;
	logic [1:0] ExpCode;
	logic [7:0] ExpValue;
	logic [7:0][6:0] Stage1;	// Selector stage
	logic [7:0][6:0] Stage2;	// Segment stage, what the panel shows
	logic Stage1Done;
	logic Stage2Done;
	logic Stage2Run;
	logic Checking = 1'b0;
	int Errors = 0;
	int TestStartErrors = 0;
	int TestsRun = 0;
	int TestsFailed = 0;
	int Cycles = 0;
	int Strobes = 0;	// Retire strobes seen while running
	integer Seed;

	cpu_monitor_top u_dut (.*);

	initial
	begin
		i_Clk = 1'b0;
		forever #5 i_Clk = ~i_Clk;
	end

	always @(posedge i_Clk)
	begin
		Cycles <= Cycles + 1;
		if (Cycles >= CycleLimit)
		begin
			$display("Timeout: the run did not end within %0d cycles", CycleLimit);
			$display("Test failures found");
			$finish;
		end
	end

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic logic [7:0][6:0] expectedPanel(input logic [31:0] cyc, input logic [31:0] ins,
		input logic [1:0] code, input logic [7:0] value, input logic [1:0] mode, input logic [21:0] pc);
		logic [31:0] word;
		logic [7:0][6:0] panel;
		case (mode)
			ModeStatus: word = {pc[7:0], 16'h0000, value};	// PC left, value right
			ModeCycles: word = cyc;
			ModeInstr: word = ins;
			default: word = '0;
		endcase
		for (int d = 0; d < 8; d++)
			panel[d] = HexGlyph[word[d*4 +: 4]];
		if (mode == ModeStatus)
			case (code)
				Pass: panel[2] = GlyphP;
				Fail: panel[2] = GlyphF;
				Done: panel[2] = GlyphD;
				default: panel[2] = Blank;
			endcase
		return panel;
	endfunction

	always @(posedge i_Clk or negedge i_Reset_n)
	begin
		if (!i_Reset_n)
		begin
			ExpCycles <= '0;
			ExpInstr <= '0;
			ExpCode <= Noop;
			ExpValue <= '0;
		end
		else
		begin
			if (i_LoaderDone && ExpCode != Done)	// Running
			begin
				ExpCycles <= ExpCycles + 32'd1;
				if (i_Retire)
					ExpInstr <= ExpInstr + 32'd1;
			end
			if (i_Report && i_ReportCode != Noop)
			begin
				ExpCode <= i_ReportCode;
				ExpValue <= i_ReportValue;
			end
		end
	end

	// Two register stages between model state and the panel
	always @(posedge i_Clk or negedge i_Reset_n)
	begin
		if (!i_Reset_n)
		begin
			Stage1 <= expectedPanel('0, '0, Noop, '0, ModeStatus, '0);
			Stage1Done <= 1'b0;
			Stage2 <= {8{Blank}};	// Dark in reset
			Stage2Done <= 1'b0;
			Stage2Run <= 1'b0;
		end
		else
		begin
			Stage1 <= expectedPanel(ExpCycles, ExpInstr, ExpCode, ExpValue, i_Mode, i_Pc);
			Stage1Done <= (ExpCode == Done);
			Stage2 <= Stage1;
			Stage2Done <= Stage1Done;
			Stage2Run <= !Stage1Done;
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	task automatic reportMismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		Errors++;
	endtask

	task automatic checkDigit(input int d, input logic [6:0] expected, input string label);
		assert (o_Segments[d] === expected)
		else reportMismatch($sformatf("%s digit %0d got %h expected %h", label, d,
			o_Segments[d], expected));
	endtask

	task automatic checkWord(input logic [31:0] word, input string label);
		for (int d = 0; d < 8; d++)
			checkDigit(d, HexGlyph[word[d*4 +: 4]], label);
	endtask

	// Whole panel every cycle, sampled away from the edge
	always @(negedge i_Clk)
	begin
		if (Checking)
		begin
			for (int d = 0; d < 8; d++)
				checkDigit(d, Stage2[d], "panel");
			assert (o_DoneLed === Stage2Done && o_RunLed === Stage2Run)
			else reportMismatch($sformatf("LEDs got %b%b expected %b%b", o_DoneLed, o_RunLed,
				Stage2Done, Stage2Run));
		end
	end

	task automatic waitCycles(input int n);
		repeat (n) @(posedge i_Clk);
		#1;	// Inputs change just after the edge
	endtask

	task automatic sendReport(input logic [1:0] code, input logic [7:0] value);
		i_Report = 1'b1;
		i_ReportCode = code;
		i_ReportValue = value;
		waitCycles(1);
		i_Report = 1'b0;
	endtask

	task automatic randomRetire(input int n);
		int rnd;
		repeat (n)
		begin
			rnd = $random(Seed);
			i_Retire = rnd[0];
			if (i_Retire && i_LoaderDone && ExpCode != Done)
				Strobes++;	// Counted on the coming edge
			waitCycles(1);
		end
		i_Retire = 1'b0;
	endtask

	task automatic endTest(input string name);
		int total;
		total = Errors + u_dut.u_perfMonitor.u_properties.FailCount;	// Bound assertions too
		TestsRun++;
		if (total != TestStartErrors)
			TestsFailed++;
		$display("Test %0d %s: %s", TestsRun, name, (total == TestStartErrors) ? "ok" : "FAILED");
		TestStartErrors = total;
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial
	begin
		Seed = 39769;
		i_Reset_n = 1'b0;
		i_LoaderDone = 1'b0;
		i_Retire = 1'b0;
		i_Report = 1'b0;
		i_ReportCode = Noop;
		i_ReportValue = '0;
		i_Pc = '0;
		i_Mode = ModeStatus;
		repeat (2) @(posedge i_Clk);
		#1;
		i_Reset_n = 1'b1;

		for (int d = 0; d < 8; d++)
			checkDigit(d, Blank, "reset");
		assert (o_DoneLed === 1'b0) else reportMismatch("done LED lit in reset");
		Checking = 1'b1;
		waitCycles(2);
		for (int d = 0; d < 8; d++)
			checkDigit(d, (d == 2) ? Blank : HexGlyph[0], "after reset");
		assert (o_RunLed === 1'b1) else reportMismatch("run LED dark after reset");
		endTest("after reset");

		i_Mode = ModeCycles;
		i_LoaderDone = 1'b1;
		waitCycles(500);	// 500 running edges
		i_LoaderDone = 1'b0;
		waitCycles(3);
		checkWord(32'd500, "cycle count");
		waitCycles(40);
		checkWord(32'd500, "cycle hold");	// Loader low, no counting
		endTest("cycle counting");

		i_Mode = ModeInstr;
		i_LoaderDone = 1'b1;
		randomRetire(600);
		waitCycles(2);
		checkWord(Strobes, "retired count");
		endTest("instruction counting");

		i_Mode = ModeStatus;
		i_Pc = 22'h2A5C3;
		sendReport(Pass, 8'h5E);
		waitCycles(2);
		checkDigit(2, GlyphP, "pass glyph");
		checkDigit(0, HexGlyph[4'hE], "pass value");
		checkDigit(1, HexGlyph[4'h5], "pass value");
		checkDigit(6, HexGlyph[4'h3], "pc byte");
		checkDigit(7, HexGlyph[4'hC], "pc byte");
		sendReport(Fail, 8'h17);
		waitCycles(2);
		checkDigit(2, GlyphF, "fail glyph");
		sendReport(Noop, 8'hFF);	// Must be ignored
		waitCycles(2);
		checkDigit(2, GlyphF, "noop glyph");
		checkDigit(0, HexGlyph[4'h7], "noop value");
		endTest("report capture");

		sendReport(Done, 8'h00);
		waitCycles(2);
		checkDigit(2, GlyphD, "done glyph");
		assert (o_DoneLed === 1'b1 && o_RunLed === 1'b0) else reportMismatch("LEDs do not show done");
		i_Mode = ModeInstr;
		randomRetire(100);	// Strobes keep coming, count stays
		waitCycles(2);
		checkWord(Strobes, "frozen count");
		endTest("done report");

		i_Mode = ModeSpare;
		waitCycles(3);
		checkWord(32'd0, "spare");
		i_Mode = ModeCycles;
		waitCycles(3);
		checkWord(ExpCycles, "frozen cycles");	// Digit 2 is a counter nibble here
		endTest("spare mode");

		Checking = 1'b0;
		Errors += u_dut.u_perfMonitor.u_properties.FailCount;
		$display("Tests run: %0d, failed: %0d, mismatches: %0d", TestsRun, TestsFailed, Errors);
		if (Errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
